//--- Bender.yml
package:
  name: mem_port_arbiter

sources:
  - common/mem_cfg_pkg.sv
  - common/mem_types_pkg.sv
  - common/w_route_if.sv
  - hdl/req_arbiter.sv
  - hdl/w_route_fifo.sv
  - hdl/w_data_mux.sv
  - hdl/rsp_router.sv
  - hdl/mem_port_arbiter.sv
  - target: test
    files:
      - sim/mem_port_arbiter_assert.sv
      - sim/tb_mem_port_arbiter.sv

//--- common/mem_cfg_pkg.sv
// memory port configuration
// channel widths, requester indices and their ID prefix codes

`default_nettype none

package mem_cfg_pkg;

  // ------------------------------
  // requesters
  // ------------------------------
  localparam int unsigned NUM_SRC   = 3;
  localparam int unsigned SRC_IDX_W = 2;

  localparam logic [SRC_IDX_W-1:0] SRC_ICACHE = 2'd0;
  localparam logic [SRC_IDX_W-1:0] SRC_BYPASS = 2'd1;
  localparam logic [SRC_IDX_W-1:0] SRC_DCACHE = 2'd2;

  // ------------------------------
  // channel widths
  // ------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  // burst length, beats minus one
  localparam int unsigned LEN_W  = 4;
  localparam int unsigned TAG_W  = 2;
  localparam int unsigned ID_W   = 4;
  // source code sits above the tag
  localparam int unsigned CODE_W = ID_W - TAG_W;

  // ID prefix per source index, index 0 in the low slot
  localparam logic [NUM_SRC-1:0][CODE_W-1:0] SRC_CODE = {2'b11, 2'b10, 2'b00};

  // write ownership FIFO
  localparam int unsigned WFIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- common/mem_types_pkg.sv
// response payload types
// one data word, read as data on reads and as a response code on writes

`default_nettype none

package mem_types_pkg;

  localparam int unsigned RESP_W = 2;

  typedef logic [RESP_W-1:0] resp_code_t;

  localparam resp_code_t RESP_OKAY   = 2'b00;
  localparam resp_code_t RESP_SLVERR = 2'b10;
  localparam resp_code_t RESP_DECERR = 2'b11;

  // write view, code in the low bits
  typedef struct packed {
    logic [mem_cfg_pkg::DATA_W-RESP_W-1:0] rsvd;
    resp_code_t                            code;
  } rsp_wr_view_t;

  typedef union packed {
    logic [mem_cfg_pkg::DATA_W-1:0] rdata;
    rsp_wr_view_t                   wr;
  } rsp_payload_u;

endpackage

`default_nettype wire

//--- common/w_route_if.sv
// write route link
// carries write ownership from the request arbiter through the
// owner FIFO to the write data mux

`timescale 1ns/1ps
`default_nettype none

interface w_route_if;
  import mem_cfg_pkg::*;

  // producer side
  logic                 push;
  logic [SRC_IDX_W-1:0] push_src;
  logic                 full;

  // consumer side
  logic [SRC_IDX_W-1:0] head_src;
  logic                 head_valid;
  logic                 pop;

  modport arb (
    output push,
    output push_src,
    input  full
  );

  modport fifo (
    input  push,
    input  push_src,
    output full,
    output head_src,
    output head_valid,
    input  pop
  );

  modport mux (
    input  head_src,
    input  head_valid,
    output pop
  );

endinterface

`default_nettype wire

//--- hdl/mem_port_arbiter.sv
// memory-side port of the cache subsystem
// icache, bypass and dcache share one request, write data and
// response channel

`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  // source requests
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_req_valid_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_req_ready_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::ADDR_W-1:0] src_req_addr_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::TAG_W-1:0]  src_req_tag_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_req_write_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::LEN_W-1:0]  src_req_len_i,
  // source write data
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_valid_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_ready_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::DATA_W-1:0] src_w_data_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::STRB_W-1:0] src_w_strb_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_last_i,
  // source responses
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_rsp_valid_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_rsp_ready_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::TAG_W-1:0]  src_rsp_tag_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_rsp_write_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::DATA_W-1:0] src_rsp_rdata_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_rsp_err_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_rsp_last_o,
  // memory request
  output logic                                                    mem_req_valid_o,
  input  logic                                                    mem_req_ready_i,
  output logic [mem_cfg_pkg::ADDR_W-1:0]                          mem_req_addr_o,
  output logic [mem_cfg_pkg::ID_W-1:0]                            mem_req_id_o,
  output logic                                                    mem_req_write_o,
  output logic [mem_cfg_pkg::LEN_W-1:0]                           mem_req_len_o,
  // memory write data
  output logic                                                    mem_w_valid_o,
  input  logic                                                    mem_w_ready_i,
  output logic [mem_cfg_pkg::DATA_W-1:0]                          mem_w_data_o,
  output logic [mem_cfg_pkg::STRB_W-1:0]                          mem_w_strb_o,
  output logic                                                    mem_w_last_o,
  // memory response
  input  logic                                                    mem_rsp_valid_i,
  output logic                                                    mem_rsp_ready_o,
  input  logic [mem_cfg_pkg::ID_W-1:0]                            mem_rsp_id_i,
  input  logic                                                    mem_rsp_write_i,
  input  mem_types_pkg::rsp_payload_u                             mem_rsp_payload_i,
  input  logic                                                    mem_rsp_last_i
);

  // write ownership link
  w_route_if w_route ();

  req_arbiter u_req_arbiter (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .src_req_valid_i (src_req_valid_i),
    .src_req_ready_o (src_req_ready_o),
    .src_req_addr_i  (src_req_addr_i),
    .src_req_tag_i   (src_req_tag_i),
    .src_req_write_i (src_req_write_i),
    .src_req_len_i   (src_req_len_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_id_o    (mem_req_id_o),
    .mem_req_write_o (mem_req_write_o),
    .mem_req_len_o   (mem_req_len_o),
    .route           (w_route.arb)
  );

  w_route_fifo u_w_route_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .route    (w_route.fifo)
  );

  w_data_mux u_w_data_mux (
    .src_w_valid_i (src_w_valid_i),
    .src_w_ready_o (src_w_ready_o),
    .src_w_data_i  (src_w_data_i),
    .src_w_strb_i  (src_w_strb_i),
    .src_w_last_i  (src_w_last_i),
    .mem_w_valid_o (mem_w_valid_o),
    .mem_w_ready_i (mem_w_ready_i),
    .mem_w_data_o  (mem_w_data_o),
    .mem_w_strb_o  (mem_w_strb_o),
    .mem_w_last_o  (mem_w_last_o),
    .route         (w_route.mux)
  );

  rsp_router u_rsp_router (
    .mem_rsp_valid_i   (mem_rsp_valid_i),
    .mem_rsp_ready_o   (mem_rsp_ready_o),
    .mem_rsp_id_i      (mem_rsp_id_i),
    .mem_rsp_write_i   (mem_rsp_write_i),
    .mem_rsp_payload_i (mem_rsp_payload_i),
    .mem_rsp_last_i    (mem_rsp_last_i),
    .src_rsp_valid_o   (src_rsp_valid_o),
    .src_rsp_ready_i   (src_rsp_ready_i),
    .src_rsp_tag_o     (src_rsp_tag_o),
    .src_rsp_write_o   (src_rsp_write_o),
    .src_rsp_rdata_o   (src_rsp_rdata_o),
    .src_rsp_err_o     (src_rsp_err_o),
    .src_rsp_last_o    (src_rsp_last_o)
  );

endmodule

`default_nettype wire

//--- hdl/req_arbiter.sv
// round-robin request arbiter
// merges the three request channels onto one, tags the ID with the
// source code and records the owner of every accepted write

`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                        src_req_valid_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                        src_req_ready_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::ADDR_W-1:0] src_req_addr_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::TAG_W-1:0]  src_req_tag_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                        src_req_write_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::LEN_W-1:0]  src_req_len_i,
  output logic                                                   mem_req_valid_o,
  input  logic                                                   mem_req_ready_i,
  output logic [mem_cfg_pkg::ADDR_W-1:0]                         mem_req_addr_o,
  output logic [mem_cfg_pkg::ID_W-1:0]                           mem_req_id_o,
  output logic                                                   mem_req_write_o,
  output logic [mem_cfg_pkg::LEN_W-1:0]                          mem_req_len_o,
  w_route_if.arb                                                 route
);
  import mem_cfg_pkg::*;

  logic [NUM_SRC-1:0]   eligible;
  logic [SRC_IDX_W-1:0] rr_ptr_q;
  logic [SRC_IDX_W-1:0] lock_src_q;
  logic                 lock_q;
  logic [SRC_IDX_W-1:0] pick_src;
  logic                 pick_valid;
  logic [SRC_IDX_W-1:0] grant_src;
  logic                 req_fire;

  function automatic logic [SRC_IDX_W-1:0] next_src(input logic [SRC_IDX_W-1:0] src);
    if (src == SRC_IDX_W'(NUM_SRC - 1)) begin
      return '0;
    end
    return src + 1'b1;
  endfunction

  // writes wait while the owner FIFO has no room, reads never do
  assign eligible = src_req_valid_i & (~src_req_write_i | {NUM_SRC{~route.full}});

  // ------------------------------
  // round-robin pick
  // ------------------------------
  always_comb begin
    int unsigned idx;
    pick_valid = 1'b0;
    pick_src   = rr_ptr_q;
    for (int unsigned k = 0; k < NUM_SRC; k++) begin
      idx = rr_ptr_q + k;
      if (idx >= NUM_SRC) begin
        idx = idx - NUM_SRC;
      end
      if (!pick_valid && eligible[idx]) begin
        pick_valid = 1'b1;
        pick_src   = SRC_IDX_W'(idx);
      end
    end
  end

  // a stalled grant stays put so the payload is stable
  assign grant_src       = lock_q ? lock_src_q : pick_src;
  assign mem_req_valid_o = lock_q ? eligible[lock_src_q] : pick_valid;
  assign req_fire        = mem_req_valid_o & mem_req_ready_i;

  assign mem_req_addr_o  = src_req_addr_i[grant_src];
  assign mem_req_id_o    = {SRC_CODE[grant_src], src_req_tag_i[grant_src]};
  assign mem_req_write_o = src_req_write_i[grant_src];
  assign mem_req_len_o   = src_req_len_i[grant_src];

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      src_req_ready_o[i] = req_fire & (grant_src == SRC_IDX_W'(i));
    end
  end

  // record owner of each accepted write
  assign route.push     = req_fire & mem_req_write_o;
  assign route.push_src = grant_src;

  // ------------------------------
  // pointer and lock
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_src_q <= '0;
    end else begin
      lock_q <= mem_req_valid_o & ~mem_req_ready_i;
      if (mem_req_valid_o) begin
        lock_src_q <= grant_src;
      end
      // next search starts after the source just served
      if (req_fire) begin
        rr_ptr_q <= next_src(grant_src);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rsp_router.sv
// response router
// steers the shared response channel to one source by ID prefix and
// decodes the payload, unmapped prefixes are swallowed

`timescale 1ns/1ps
`default_nettype none

module rsp_router (
  input  logic                                                  mem_rsp_valid_i,
  output logic                                                  mem_rsp_ready_o,
  input  logic [mem_cfg_pkg::ID_W-1:0]                          mem_rsp_id_i,
  input  logic                                                  mem_rsp_write_i,
  input  mem_types_pkg::rsp_payload_u                           mem_rsp_payload_i,
  input  logic                                                  mem_rsp_last_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                       src_rsp_valid_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                       src_rsp_ready_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::TAG_W-1:0]  src_rsp_tag_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                       src_rsp_write_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::DATA_W-1:0] src_rsp_rdata_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                       src_rsp_err_o,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                       src_rsp_last_o
);
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  logic [CODE_W-1:0]    code;
  logic [SRC_IDX_W-1:0] sel;
  logic                 hit;

  assign code = mem_rsp_id_i[ID_W-1 -: CODE_W];

  // prefix to source index
  always_comb begin
    hit = 1'b1;
    sel = SRC_ICACHE;
    case (code)
      SRC_CODE[SRC_ICACHE]: sel = SRC_ICACHE;
      SRC_CODE[SRC_BYPASS]: sel = SRC_BYPASS;
      SRC_CODE[SRC_DCACHE]: sel = SRC_DCACHE;
      default:              hit = 1'b0;
    endcase
  end

  // ------------------------------
  // per source outputs
  // ------------------------------
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      src_rsp_valid_o[i] = mem_rsp_valid_i & hit & (sel == SRC_IDX_W'(i));
      src_rsp_tag_o[i]   = mem_rsp_id_i[TAG_W-1:0];
      src_rsp_write_o[i] = mem_rsp_write_i;
      src_rsp_rdata_o[i] = mem_rsp_write_i ? '0 : mem_rsp_payload_i.rdata;
      // reads carry no error
      src_rsp_err_o[i]   = mem_rsp_write_i & (mem_rsp_payload_i.wr.code != RESP_OKAY);
      src_rsp_last_o[i]  = mem_rsp_last_i;
    end
  end

  // unknown prefix is accepted and dropped
  assign mem_rsp_ready_o = hit ? src_rsp_ready_i[sel] : 1'b1;

endmodule

`default_nettype wire

//--- hdl/w_data_mux.sv
// write data mux
// forwards the beats of the source that owns the oldest open write,
// the memory port carries no write ID on data

`timescale 1ns/1ps
`default_nettype none

module w_data_mux (
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_valid_i,
  output logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_ready_o,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::DATA_W-1:0] src_w_data_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0][mem_cfg_pkg::STRB_W-1:0] src_w_strb_i,
  input  logic [mem_cfg_pkg::NUM_SRC-1:0]                         src_w_last_i,
  output logic                                                    mem_w_valid_o,
  input  logic                                                    mem_w_ready_i,
  output logic [mem_cfg_pkg::DATA_W-1:0]                          mem_w_data_o,
  output logic [mem_cfg_pkg::STRB_W-1:0]                          mem_w_strb_o,
  output logic                                                    mem_w_last_o,
  w_route_if.mux                                                  route
);
  import mem_cfg_pkg::*;

  logic [SRC_IDX_W-1:0] sel;
  logic                 beat_fire;

  assign sel = route.head_src;

  // ------------------------------
  // beat forwarding
  // ------------------------------
  // nothing moves without an owner at the head
  assign mem_w_valid_o = route.head_valid & src_w_valid_i[sel];
  assign mem_w_data_o  = src_w_data_i[sel];
  assign mem_w_strb_o  = src_w_strb_i[sel];
  assign mem_w_last_o  = src_w_last_i[sel];

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      src_w_ready_o[i] = route.head_valid & mem_w_ready_i & (sel == SRC_IDX_W'(i));
    end
  end

  // last beat closes the write and frees its owner entry
  assign beat_fire = mem_w_valid_o & mem_w_ready_i;
  assign route.pop = beat_fire & mem_w_last_o;

endmodule

`default_nettype wire

//--- hdl/w_route_fifo.sv
// write owner FIFO
// fall-through circular buffer of source indices, one entry per
// accepted write, released by the last beat of that write

`timescale 1ns/1ps
`default_nettype none

module w_route_fifo (
  input  logic    clk_i,
  input  logic    arst_n_i,
  w_route_if.fifo route
);
  import mem_cfg_pkg::*;

  localparam int unsigned PTR_W = $clog2(WFIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(WFIFO_DEPTH + 1);

  logic [SRC_IDX_W-1:0] mem_q [WFIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 empty;
  logic                 wr_en;
  logic                 rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(WFIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty      = (cnt_q == '0);
  assign route.full = (cnt_q == CNT_W'(WFIFO_DEPTH));

  // empty FIFO shows the incoming push straight away
  assign route.head_valid = ~empty | route.push;
  assign route.head_src   = empty ? route.push_src : mem_q[rd_ptr_q];

  // push and pop on an empty FIFO pass through without storing
  assign wr_en = route.push & ~route.full & ~(empty & route.pop);
  assign rd_en = route.pop & ~empty;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= route.push_src;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (wr_en && !rd_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim.f
common/mem_cfg_pkg.sv
common/mem_types_pkg.sv
common/w_route_if.sv
hdl/req_arbiter.sv
hdl/w_route_fifo.sv
hdl/w_data_mux.sv
hdl/rsp_router.sv
hdl/mem_port_arbiter.sv
sim/mem_port_arbiter_assert.sv
sim/tb_mem_port_arbiter.sv

//--- sim/mem_port_arbiter_assert.sv
// protocol assertions on the memory request channel
// bound into the top level

`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter_assert (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input logic [mem_cfg_pkg::ADDR_W-1:0] req_addr_i,
  input logic [mem_cfg_pkg::ID_W-1:0]   req_id_i,
  input logic                           req_write_i,
  input logic [mem_cfg_pkg::LEN_W-1:0]  req_len_i,
  input logic                           full_i
);
  import mem_cfg_pkg::*;

  // code 01 belongs to no source
  a_id_prefix : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> req_id_i[ID_W-1 -: CODE_W] != 2'b01)
    else $error("request ID prefix 01 on memory channel");

  a_req_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && !req_ready_i) |=>
      (req_valid_i && $stable({req_addr_i, req_id_i, req_write_i, req_len_i})))
    else $error("memory request changed while stalled");

  a_no_write_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(req_valid_i && req_ready_i && req_write_i && full_i))
    else $error("write accepted with owner FIFO full");

endmodule

bind mem_port_arbiter mem_port_arbiter_assert u_assert (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_valid_i (mem_req_valid_o),
  .req_ready_i (mem_req_ready_i),
  .req_addr_i  (mem_req_addr_o),
  .req_id_i    (mem_req_id_o),
  .req_write_i (mem_req_write_o),
  .req_len_i   (mem_req_len_o),
  .full_i      (w_route.full)
);

`default_nettype wire

//--- sim/tb_mem_port_arbiter.sv
// testbench for the memory-side port
// random traffic from three sources, a behavioral memory with
// back-pressure and per-source response scoreboards

`timescale 1ns/1ps
`default_nettype none

module tb_mem_port_arbiter;
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  localparam int NUM_TXN = 40;
  localparam int TMO     = 2000;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              write;
    logic              err;
    logic              last;
    logic [DATA_W-1:0] data;
  } exp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic              write;
    logic [LEN_W-1:0]  len;
    logic [15:0]       wseq;
  } mreq_t;

  logic clk_i;
  logic arst_n_i;
  logic [NUM_SRC-1:0]             src_req_valid_i, src_req_ready_o, src_req_write_i;
  logic [NUM_SRC-1:0][ADDR_W-1:0] src_req_addr_i;
  logic [NUM_SRC-1:0][TAG_W-1:0]  src_req_tag_i, src_rsp_tag_o;
  logic [NUM_SRC-1:0][LEN_W-1:0]  src_req_len_i;
  logic [NUM_SRC-1:0]             src_w_valid_i, src_w_ready_o, src_w_last_i;
  logic [NUM_SRC-1:0][DATA_W-1:0] src_w_data_i, src_rsp_rdata_o;
  logic [NUM_SRC-1:0][STRB_W-1:0] src_w_strb_i;
  logic [NUM_SRC-1:0]             src_rsp_valid_o, src_rsp_ready_i, src_rsp_write_o;
  logic [NUM_SRC-1:0]             src_rsp_err_o, src_rsp_last_o;
  logic              mem_req_valid_o, mem_req_ready_i, mem_req_write_o;
  logic [ADDR_W-1:0] mem_req_addr_o;
  logic [ID_W-1:0]   mem_req_id_o, mem_rsp_id_i;
  logic [LEN_W-1:0]  mem_req_len_o;
  logic              mem_w_valid_o, mem_w_ready_i, mem_w_last_o;
  logic [DATA_W-1:0] mem_w_data_o;
  logic [STRB_W-1:0] mem_w_strb_o;
  logic              mem_rsp_valid_i, mem_rsp_ready_o, mem_rsp_write_i, mem_rsp_last_i;
  rsp_payload_u      mem_rsp_payload_i;

  // scoreboards and memory model state
  exp_t       sb_q [NUM_SRC][$];
  logic [5:0] pw_q [NUM_SRC][$];
  mreq_t      req_q [$];
  mreq_t      wq [$];
  logic [NUM_SRC-1:0] req_done;
  int pass_cnt [NUM_SRC][NUM_SRC];
  int req_cnt, wseq_next, wdone_cnt, mem_wbeat, rsp_beat, t;
  int g;
  logic rsp_fired, rsp_inject, inject_req, inject_done;

  mem_port_arbiter dut_i (.*);

  always #50 clk_i = ~clk_i;

  // ------------------------------
  // reference rules
  // ------------------------------
  function automatic logic [DATA_W-1:0] ref_rdata(input logic [ADDR_W-1:0] addr,
                                                  input logic [ID_W-1:0] id, input int beat);
    return addr ^ {id, 20'h5a3c1, 8'(beat)};
  endfunction

  function automatic logic [DATA_W-1:0] wdata_rule(input int src, input logic [1:0] tag,
                                                   input int beat);
    return {8'hd0, 6'h0, 2'(src), 6'h0, tag, 8'(beat)};
  endfunction

  // strobe pattern differs per source and beat
  function automatic logic [STRB_W-1:0] wstrb_rule(input int src, input int beat);
    return ~{2'(beat), 2'(src)};
  endfunction

  function automatic logic [1:0] src_code(input int s);
    return (s == 0) ? 2'b00 : (s == 1) ? 2'b10 : 2'b11;
  endfunction

  function automatic int code_to_src(input logic [1:0] code);
    case (code)
      2'b00:   return 0;
      2'b10:   return 1;
      2'b11:   return 2;
      default: return -1;
    endcase
  endfunction

  task automatic fail_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, what, act, exp);
      fail_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s did not happen in time", what);
    fail_run();
  endtask

  // ------------------------------
  // source drivers
  // ------------------------------
  task automatic issue_requests(input int s);
    logic [ADDR_W-1:0] addr;
    logic [1:0] tag;
    logic wr;
    logic [LEN_W-1:0] len;
    exp_t e;
    int n;
    int k;
    for (n = 0; n < NUM_TXN; n++) begin
      repeat ($urandom_range(0, 1)) begin
        @(posedge clk_i);
        #1;
      end
      wr   = $urandom_range(0, 1);
      len  = $urandom_range(0, 3);
      tag  = $urandom_range(0, 3);
      addr = {($urandom_range(0, 3) == 0), 31'($urandom) & 31'h7fff_fff0};
      src_req_valid_i[s] = 1'b1;
      src_req_write_i[s] = wr;
      src_req_len_i[s]   = len;
      src_req_tag_i[s]   = tag;
      src_req_addr_i[s]  = addr;
      k = 0;
      do begin
        @(negedge clk_i);
        k++;
        if (k > TMO) timeout_fail($sformatf("request grant at source %0d", s));
      end while (!src_req_ready_o[s]);
      if (wr) begin
        pw_q[s].push_back({tag, len});
        e = '{tag: tag, write: 1'b1, err: addr[31], last: 1'b1, data: '0};
        sb_q[s].push_back(e);
      end else begin
        for (int b = 0; b <= len; b++) begin
          e = '{tag: tag, write: 1'b0, err: 1'b0, last: (b == len),
                data: ref_rdata(addr, {src_code(s), tag}, b)};
          sb_q[s].push_back(e);
        end
      end
      @(posedge clk_i);
      #1;
      src_req_valid_i[s] = 1'b0;
    end
    req_done[s] = 1'b1;
  endtask

  task automatic send_wdata(input int s);
    logic [5:0] pw;
    int k;
    while (!(req_done[s] && pw_q[s].size() == 0)) begin
      k = 0;
      while (pw_q[s].size() == 0 && !req_done[s]) begin
        @(posedge clk_i);
        #1;
        k++;
        if (k > TMO) timeout_fail($sformatf("write request at source %0d", s));
      end
      if (pw_q[s].size() > 0) begin
        pw = pw_q[s].pop_front();
        for (int b = 0; b <= pw[3:0]; b++) begin
          src_w_valid_i[s] = 1'b1;
          src_w_data_i[s]  = wdata_rule(s, pw[5:4], b);
          src_w_strb_i[s]  = wstrb_rule(s, b);
          src_w_last_i[s]  = (b == pw[3:0]);
          k = 0;
          do begin
            @(negedge clk_i);
            k++;
            if (k > TMO) timeout_fail($sformatf("write beat at source %0d", s));
          end while (!src_w_ready_o[s]);
          @(posedge clk_i);
          #1;
          src_w_valid_i[s] = 1'b0;
        end
      end
    end
  endtask

  // ------------------------------
  // memory model
  // ------------------------------
  always @(posedge clk_i) begin
    #1;
    mem_req_ready_i = ($urandom_range(0, 3) != 0);
    mem_w_ready_i   = ($urandom_range(0, 3) != 0);
    src_rsp_ready_i = NUM_SRC'($urandom);
  end

  // a presented response holds until it is taken
  always @(posedge clk_i) begin
    #1;
    if (!mem_rsp_valid_i || rsp_fired) begin
      if (rsp_fired) begin
        rsp_fired = 1'b0;
        if (rsp_inject) begin
          rsp_inject  = 1'b0;
          inject_done = 1'b1;
        end else if (req_q[0].write || rsp_beat == req_q[0].len) begin
          void'(req_q.pop_front());
          rsp_beat = 0;
        end else begin
          rsp_beat++;
        end
      end
      mem_rsp_valid_i = 1'b0;
      if (inject_req && !inject_done) begin
        rsp_inject        = 1'b1;
        mem_rsp_valid_i   = 1'b1;
        mem_rsp_id_i      = 4'b0100;
        mem_rsp_write_i   = 1'b0;
        mem_rsp_last_i    = 1'b1;
        mem_rsp_payload_i = 32'hdead_beef;
      end else if (req_q.size() > 0 && $urandom_range(0, 3) != 0) begin
        if (!req_q[0].write || wdone_cnt > req_q[0].wseq) begin
          mem_rsp_valid_i = 1'b1;
          mem_rsp_id_i    = req_q[0].id;
          mem_rsp_write_i = req_q[0].write;
          mem_rsp_last_i  = req_q[0].write || (rsp_beat == req_q[0].len);
          mem_rsp_payload_i = '0;
          if (req_q[0].write) begin
            mem_rsp_payload_i.wr.code = req_q[0].addr[31] ? RESP_SLVERR : RESP_OKAY;
          end else begin
            mem_rsp_payload_i.rdata = ref_rdata(req_q[0].addr, req_q[0].id, rsp_beat);
          end
        end
      end
    end
  end

  // memory side transfers taken at the falling edge
  always @(negedge clk_i) begin
    if (mem_req_valid_o && mem_req_ready_i) begin
      req_q.push_back(mreq_t'{addr: mem_req_addr_o, id: mem_req_id_o, write: mem_req_write_o,
                              len: mem_req_len_o, wseq: 16'(wseq_next)});
      req_cnt++;
      if (mem_req_write_o) begin
        wq.push_back(req_q[$]);
        wseq_next++;
      end
      // no waiting source is passed twice by the same source
      g = code_to_src(mem_req_id_o[3:2]);
      for (int o = 0; o < NUM_SRC; o++) begin
        if (o != g && src_req_valid_i[o]
            && !(src_req_write_i[o] && dut_i.w_route.full)) begin
          pass_cnt[o][g]++;
          check_eq(pass_cnt[o][g] < 2, 1, $sformatf("source %0d passed twice by %0d", o, g));
        end
      end
      for (int o = 0; o < NUM_SRC; o++) pass_cnt[g][o] = 0;
    end
    for (int o = 0; o < NUM_SRC; o++) begin
      if (!src_req_valid_i[o] || (src_req_write_i[o] && dut_i.w_route.full)) begin
        for (int j = 0; j < NUM_SRC; j++) pass_cnt[o][j] = 0;
      end
    end
    if (mem_w_valid_o && mem_w_ready_i) begin
      if (wq.size() == 0) begin
        $display("write beat arrived with no open write request");
        fail_run();
      end
      check_eq(mem_w_data_o, wdata_rule(code_to_src(wq[0].id[3:2]), wq[0].id[1:0], mem_wbeat),
               "write beat data");
      check_eq(mem_w_strb_o, wstrb_rule(code_to_src(wq[0].id[3:2]), mem_wbeat),
               "write beat strobe");
      check_eq(mem_w_last_o, (mem_wbeat == wq[0].len), "write beat last");
      if (mem_w_last_o) begin
        void'(wq.pop_front());
        mem_wbeat = 0;
        wdone_cnt++;
      end else begin
        mem_wbeat++;
      end
    end
    if (mem_rsp_valid_i && mem_rsp_id_i[3:2] == 2'b01) begin
      check_eq(mem_rsp_ready_o, 1'b1, "unmapped response ready");
      check_eq(src_rsp_valid_o, '0, "unmapped response reached a source");
    end
    if (mem_rsp_valid_i && mem_rsp_ready_o) rsp_fired = 1'b1;
  end

  // ------------------------------
  // response checker
  // ------------------------------
  always @(negedge clk_i) begin
    for (int s = 0; s < NUM_SRC; s++) begin
      if (src_rsp_valid_o[s] && src_rsp_ready_i[s]) begin
        if (sb_q[s].size() == 0) begin
          $display("source %0d got a response with nothing outstanding", s);
          fail_run();
        end
        check_eq({src_rsp_tag_o[s], src_rsp_write_o[s], src_rsp_err_o[s], src_rsp_last_o[s],
                  src_rsp_rdata_o[s]}, sb_q[s].pop_front(),
                 $sformatf("response at source %0d", s));
      end
    end
  end

  initial begin
    void'($urandom(12));
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    src_req_valid_i = '0;
    src_req_write_i = '0;
    src_req_addr_i = '0;
    src_req_tag_i = '0;
    src_req_len_i = '0;
    src_w_valid_i = '0;
    src_w_data_i = '0;
    src_w_strb_i = '1;
    src_w_last_i = '0;
    src_rsp_ready_i = '0;
    mem_req_ready_i = 1'b0;
    mem_w_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_id_i = '0;
    mem_rsp_write_i = 1'b0;
    mem_rsp_last_i = 1'b0;
    mem_rsp_payload_i = '0;
    req_done = '0;
    pass_cnt = '{default: 0};
    {req_cnt, wseq_next, wdone_cnt, mem_wbeat, rsp_beat} = '0;
    {rsp_fired, rsp_inject, inject_req, inject_done} = '0;
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    fork
      issue_requests(0);
      issue_requests(1);
      issue_requests(2);
      send_wdata(0);
      send_wdata(1);
      send_wdata(2);
      begin
        repeat (200) @(negedge clk_i);
        inject_req = 1'b1;
      end
    join
    t = 0;
    while (sb_q[0].size() + sb_q[1].size() + sb_q[2].size() + req_q.size() + wq.size() > 0
           || !inject_done) begin
      @(posedge clk_i);
      t++;
      if (t > 20 * TMO) timeout_fail("draining of outstanding responses");
    end
    if (req_cnt == NUM_SRC * NUM_TXN) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      check_eq(req_cnt, NUM_SRC * NUM_TXN, "memory request count");
    end
  end

endmodule

`default_nettype wire
